//--- src/core_pkg.sv
package core_pkg;

	localparam int xlen  = 32;	// Data width
	localparam int pc_w  = 12;	// 4 KiB instruction space
	localparam int dm_aw = 10;	// 1024-word data memory

	// Major opcodes of the supported subset
	localparam logic [6:0] opc_lui   = 7'b0110111;
	localparam logic [6:0] opc_opimm = 7'b0010011;
	localparam logic [6:0] opc_op    = 7'b0110011;
	localparam logic [6:0] opc_load  = 7'b0000011;
	localparam logic [6:0] opc_store = 7'b0100011;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_sll, alu_srl, alu_passb
	} alu_op_t;

	typedef enum logic [1:0] {ld_none, ld_word, ld_byteu} ld_sel_t;
	typedef enum logic [1:0] {st_none, st_word, st_byte} st_sel_t;
	typedef enum logic [1:0] {wb_alu, wb_load, wb_imm} wb_sel_t;	// WB data source

	// ID/EXE payload
	typedef struct packed {
		logic [xlen-1:0] op_a;
		logic [xlen-1:0] op_b;		// Already muxed with the immediate
		logic [xlen-1:0] st_data;	// Forwarded rs2
		logic [xlen-1:0] imm;
		logic [4:0]      rd;
		alu_op_t         alu_op;
		ld_sel_t         ld_sel;
		st_sel_t         st_sel;
		wb_sel_t         wb_sel;
		logic            wr_en;
	} id_ex_t;

	// EXE/MEM payload
	typedef struct packed {
		logic [xlen-1:0] alu_res;	// Also the byte address for loads and stores
		logic [xlen-1:0] st_data;
		logic [xlen-1:0] imm;
		logic [4:0]      rd;
		ld_sel_t         ld_sel;
		st_sel_t         st_sel;
		wb_sel_t         wb_sel;
		logic            wr_en;
	} ex_mem_t;

	// MEM/WB payload
	typedef struct packed {
		logic [xlen-1:0] alu_res;
		logic [xlen-1:0] ld_data;
		logic [xlen-1:0] imm;
		logic [4:0]      rd;
		wb_sel_t         wb_sel;
		logic            wr_en;
	} mem_wb_t;

endpackage

//--- src/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
	parameter type payload_t = logic
) (
	input  logic     CLK,
	input  logic     reset,
	input  logic     en,		// Stage enable, stands in for the gated clock
	input  logic     bubble,	// Insert an empty slot
	input  payload_t d,
	output payload_t q
);

	// All-zero payload means no register write and no store
	always_ff @(posedge CLK) begin
		if (reset || bubble) begin
			q <= '0;
		end else if (en) begin
			q <= d;
		end
	end

endmodule

//--- src/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
	input  logic                     CLK,
	input  logic                     reset,
	input  logic                     stall,		// Load-use hold
	output logic [core_pkg::xlen-1:0] id_inst	// IF/ID instruction
);

	import core_pkg::*;

	logic [pc_w-1:0] pc;
	logic [xlen-1:0] rom [2**(pc_w-2)];	// One word per 4 bytes
	logic [xlen-1:0] if_inst;

	// Unused words stay zero and decode as no-ops
	initial begin
		for (int i = 0; i < 2**(pc_w-2); i++) begin
			rom[i] = '0;
		end
		$readmemh("program.hex", rom);
	end

	assign if_inst = rom[pc[pc_w-1:2]];	// Asynchronous ROM read

	//////////////////////////////////////////////////////////////////////
	// PC and IF/ID register
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge CLK) begin
		if (reset) begin
			pc      <= '0;
			id_inst <= '0;		// Zero word is a no-op
		end else if (!stall) begin
			pc      <= pc + pc_w'(4);	// Wraps at 4 KiB
			id_inst <= if_inst;
		end
	end

endmodule

//--- src/decoder.sv
`timescale 1ns/1ps

module decoder (
	input  logic [core_pkg::xlen-1:0] inst,
	output core_pkg::alu_op_t         alu_op,
	output logic                      use_imm,	// op_b from immediate
	output core_pkg::ld_sel_t         ld_sel,
	output core_pkg::st_sel_t         st_sel,
	output core_pkg::wb_sel_t         wb_sel,
	output logic                      wr_en,
	output logic                      uses_rs2,
	output logic [core_pkg::xlen-1:0] imm
);

	import core_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	always_comb begin
		// Defaults give a no-op
		alu_op   = alu_add;
		use_imm  = 1'b0;
		ld_sel   = ld_none;
		st_sel   = st_none;
		wb_sel   = wb_alu;
		wr_en    = 1'b0;
		uses_rs2 = 1'b0;
		imm      = {{20{inst[31]}}, inst[31:20]};	// I-type

		case (opcode)
			opc_lui: begin
				imm     = {inst[31:12], 12'b0};	// U-type
				alu_op  = alu_passb;	// EXE result equals imm for forwarding
				use_imm = 1'b1;
				wb_sel  = wb_imm;
				wr_en   = 1'b1;
			end
			opc_opimm: begin
				use_imm = 1'b1;
				case (funct3)
					3'b000: begin
						alu_op = alu_add;		// ADDI
						wr_en  = 1'b1;
					end
					3'b001: begin
						alu_op = alu_sll;		// SLLI
						wr_en  = 1'b1;
					end
					3'b101: begin
						alu_op = alu_srl;		// SRLI only, SRAI left out
						wr_en  = (funct7 == 7'b0);
					end
					default: wr_en = 1'b0;
				endcase
			end
			opc_op: begin
				uses_rs2 = 1'b1;
				wr_en    = 1'b1;
				case (funct3)
					3'b000:  alu_op = funct7[5] ? alu_sub : alu_add;
					3'b111:  alu_op = alu_and;
					3'b110:  alu_op = alu_or;
					3'b100:  alu_op = alu_xor;
					default: wr_en = 1'b0;	// Unsupported R-type
				endcase
			end
			opc_load: begin
				use_imm = 1'b1;	// Address is rs1 + imm
				wb_sel  = wb_load;
				case (funct3)
					3'b010: begin
						ld_sel = ld_word;
						wr_en  = 1'b1;
					end
					3'b100: begin
						ld_sel = ld_byteu;
						wr_en  = 1'b1;
					end
					default: ld_sel = ld_none;
				endcase
			end
			opc_store: begin
				imm      = {{20{inst[31]}}, inst[31:25], inst[11:7]};	// S-type
				use_imm  = 1'b1;
				uses_rs2 = 1'b1;
				case (funct3)
					3'b010:  st_sel = st_word;
					3'b000:  st_sel = st_byte;
					default: st_sel = st_none;
				endcase
			end
			default: wr_en = 1'b0;
		endcase
	end

endmodule

//--- src/regfile.sv
`timescale 1ns/1ps

module regfile (
	input  logic                      CLK,
	input  logic                      reset,
	input  logic                      wr_en,
	input  logic [4:0]                wr_addr,
	input  logic [core_pkg::xlen-1:0] wr_data,
	input  logic [4:0]                rs1_addr,
	input  logic [4:0]                rs2_addr,
	output logic [core_pkg::xlen-1:0] rs1_data,
	output logic [core_pkg::xlen-1:0] rs2_data
);

	import core_pkg::*;

	logic [xlen-1:0] regs [32];

	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_addr != 5'd0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Write-through, x0 hardwired
	assign rs1_data = (rs1_addr == 5'd0) ? '0 :
		(wr_en && wr_addr == rs1_addr) ? wr_data : regs[rs1_addr];
	assign rs2_data = (rs2_addr == 5'd0) ? '0 :
		(wr_en && wr_addr == rs2_addr) ? wr_data : regs[rs2_addr];

endmodule

//--- src/alu.sv
`timescale 1ns/1ps

module alu (
	input  logic [core_pkg::xlen-1:0] op_a,
	input  logic [core_pkg::xlen-1:0] op_b,
	input  core_pkg::alu_op_t         alu_op,
	output logic [core_pkg::xlen-1:0] res
);

	import core_pkg::*;

	logic [4:0] shamt;

	assign shamt = op_b[4:0];	// Low five bits only

	always_comb begin
		case (alu_op)
			alu_add:   res = op_a + op_b;
			alu_sub:   res = op_a - op_b;
			alu_and:   res = op_a & op_b;
			alu_or:    res = op_a | op_b;
			alu_xor:   res = op_a ^ op_b;
			alu_sll:   res = op_a << shamt;
			alu_srl:   res = op_a >> shamt;	// Logical
			alu_passb: res = op_b;			// LUI
			default:   res = '0;
		endcase
	end

endmodule

//--- src/datamem.sv
`timescale 1ns/1ps

module datamem (
	input  logic                       CLK,
	input  core_pkg::ld_sel_t          ld_sel,
	input  core_pkg::st_sel_t          st_sel,
	input  logic [core_pkg::xlen-1:0]  addr,		// Byte address from MEM stage
	input  logic [core_pkg::xlen-1:0]  st_data,
	output logic [core_pkg::xlen-1:0]  ld_data,
	input  logic [3:0]                 con_write,	// Protocol byte enables
	input  logic [core_pkg::dm_aw-1:0] con_addr,
	input  logic [core_pkg::xlen-1:0]  con_in,
	output logic [core_pkg::xlen-1:0]  con_out
);

	import core_pkg::*;

	logic [xlen-1:0]  mem [2**dm_aw];
	logic [dm_aw-1:0] a_idx;
	logic [3:0]       a_be;
	logic [xlen-1:0]  a_wdata;
	logic [xlen-1:0]  a_word;

	initial begin
		for (int i = 0; i < 2**dm_aw; i++) begin
			mem[i] = '0;
		end
	end

	assign a_idx  = addr[dm_aw+1:2];
	assign a_word = mem[a_idx];

	//////////////////////////////////////////////////////////////////////
	// Port A store lanes
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		case (st_sel)
			st_word: a_be = 4'b1111;
			st_byte: a_be = 4'b0001 << addr[1:0];	// Lane from byte offset
			default: a_be = 4'b0000;
		endcase
	end

	assign a_wdata = (st_sel == st_byte) ? {4{st_data[7:0]}} : st_data;

	// Protocol write comes last so it wins per byte
	always_ff @(posedge CLK) begin
		for (int b = 0; b < 4; b++) begin
			if (a_be[b]) mem[a_idx][8*b +: 8] <= a_wdata[8*b +: 8];
			if (con_write[b]) mem[con_addr][8*b +: 8] <= con_in[8*b +: 8];
		end
	end

	// Load extraction
	always_comb begin
		case (ld_sel)
			ld_word:  ld_data = a_word;
			ld_byteu: ld_data = {24'b0, a_word[8*addr[1:0] +: 8]};	// Zero-extended
			default:  ld_data = '0;
		endcase
	end

	assign con_out = mem[con_addr];	// Asynchronous protocol read

endmodule

//--- src/core.sv
`timescale 1ns/1ps

module core (
	input  logic                       CLK,
	input  logic                       reset,
	input  logic [3:0]                 con_write,	// Protocol controller port
	input  logic [core_pkg::dm_aw-1:0] con_addr,
	input  logic [core_pkg::xlen-1:0]  con_in,
	output logic [core_pkg::xlen-1:0]  con_out		// DATAMEM read at con_addr
);

	import core_pkg::*;

	// ID stage
	logic [xlen-1:0] id_inst;
	logic [6:0]      id_opcode;
	logic [4:0]      id_rs1, id_rs2, id_rd;
	alu_op_t         id_alu_op;
	ld_sel_t         id_ld_sel;
	st_sel_t         id_st_sel;
	wb_sel_t         id_wb_sel;
	logic            id_use_imm, id_wr_en, id_uses_rs2, id_uses_rs1;
	logic [xlen-1:0] id_imm, id_rf_a, id_rf_b, id_fwd_a, id_fwd_b;
	logic            ex_hit_a, ex_hit_b, mem_hit_a, mem_hit_b, wb_hit_a, wb_hit_b;
	logic            stall;

	// Later stages
	id_ex_t          id_ex_d, id_ex_q;
	ex_mem_t         ex_mem_d, ex_mem_q;
	mem_wb_t         mem_wb_d, mem_wb_q;
	logic [xlen-1:0] ex_res;
	logic [xlen-1:0] mem_ld_data, mem_fwd_data;
	logic [xlen-1:0] wb_data;

	//////////////////////////////////////////////////////////////////////
	// IF and ID
	//////////////////////////////////////////////////////////////////////
	fetch_unit u_fetch (.CLK(CLK), .reset(reset), .stall(stall), .id_inst(id_inst));

	assign id_opcode = id_inst[6:0];
	assign id_rd     = id_inst[11:7];
	assign id_rs1    = id_inst[19:15];
	assign id_rs2    = id_inst[24:20];

	decoder u_dec (
		.inst(id_inst), .alu_op(id_alu_op), .use_imm(id_use_imm), .ld_sel(id_ld_sel),
		.st_sel(id_st_sel), .wb_sel(id_wb_sel), .wr_en(id_wr_en),
		.uses_rs2(id_uses_rs2), .imm(id_imm)
	);

	regfile u_rf (
		.CLK(CLK), .reset(reset), .wr_en(mem_wb_q.wr_en), .wr_addr(mem_wb_q.rd),
		.wr_data(wb_data), .rs1_addr(id_rs1), .rs2_addr(id_rs2),
		.rs1_data(id_rf_a), .rs2_data(id_rf_b)
	);

	// Forwarding matches, never on x0
	assign ex_hit_a  = id_ex_q.wr_en  && (id_ex_q.rd  == id_rs1) && (id_rs1 != 5'd0);
	assign ex_hit_b  = id_ex_q.wr_en  && (id_ex_q.rd  == id_rs2) && (id_rs2 != 5'd0);
	assign mem_hit_a = ex_mem_q.wr_en && (ex_mem_q.rd == id_rs1) && (id_rs1 != 5'd0);
	assign mem_hit_b = ex_mem_q.wr_en && (ex_mem_q.rd == id_rs2) && (id_rs2 != 5'd0);
	assign wb_hit_a  = mem_wb_q.wr_en && (mem_wb_q.rd == id_rs1) && (id_rs1 != 5'd0);
	assign wb_hit_b  = mem_wb_q.wr_en && (mem_wb_q.rd == id_rs2) && (id_rs2 != 5'd0);

	assign mem_fwd_data = (ex_mem_q.wb_sel == wb_load) ? mem_ld_data : ex_mem_q.alu_res;

	// Youngest producer first
	assign id_fwd_a = ex_hit_a ? ex_res : mem_hit_a ? mem_fwd_data :
		wb_hit_a ? wb_data : id_rf_a;
	assign id_fwd_b = ex_hit_b ? ex_res : mem_hit_b ? mem_fwd_data :
		wb_hit_b ? wb_data : id_rf_b;

	// Load-use hazard against the load sitting in EXE
	assign id_uses_rs1 = (id_opcode == opc_opimm) || (id_opcode == opc_op) ||
		(id_opcode == opc_load) || (id_opcode == opc_store);
	assign stall = (id_ex_q.ld_sel != ld_none) && id_ex_q.wr_en && (id_ex_q.rd != 5'd0) &&
		((id_uses_rs1 && id_ex_q.rd == id_rs1) || (id_uses_rs2 && id_ex_q.rd == id_rs2));

	always_comb begin
		id_ex_d.op_a    = id_fwd_a;
		id_ex_d.op_b    = id_use_imm ? id_imm : id_fwd_b;
		id_ex_d.st_data = id_fwd_b;		// Store data forwarded like rs2
		id_ex_d.imm     = id_imm;
		id_ex_d.rd      = id_rd;
		id_ex_d.alu_op  = id_alu_op;
		id_ex_d.ld_sel  = id_ld_sel;
		id_ex_d.st_sel  = id_st_sel;
		id_ex_d.wb_sel  = id_wb_sel;
		id_ex_d.wr_en   = id_wr_en;
	end

	pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
		.CLK(CLK), .reset(reset), .en(1'b1), .bubble(stall), .d(id_ex_d), .q(id_ex_q)
	);

	//////////////////////////////////////////////////////////////////////
	// EXE and MEM
	//////////////////////////////////////////////////////////////////////
	alu u_alu (.op_a(id_ex_q.op_a), .op_b(id_ex_q.op_b), .alu_op(id_ex_q.alu_op), .res(ex_res));

	assign ex_mem_d = '{alu_res: ex_res, st_data: id_ex_q.st_data, imm: id_ex_q.imm,
		rd: id_ex_q.rd, ld_sel: id_ex_q.ld_sel, st_sel: id_ex_q.st_sel,
		wb_sel: id_ex_q.wb_sel, wr_en: id_ex_q.wr_en};

	pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
		.CLK(CLK), .reset(reset), .en(1'b1), .bubble(1'b0), .d(ex_mem_d), .q(ex_mem_q)
	);

	datamem u_dmem (
		.CLK(CLK), .ld_sel(ex_mem_q.ld_sel), .st_sel(ex_mem_q.st_sel),
		.addr(ex_mem_q.alu_res), .st_data(ex_mem_q.st_data), .ld_data(mem_ld_data),
		.con_write(con_write), .con_addr(con_addr), .con_in(con_in), .con_out(con_out)
	);

	assign mem_wb_d = '{alu_res: ex_mem_q.alu_res, ld_data: mem_ld_data, imm: ex_mem_q.imm,
		rd: ex_mem_q.rd, wb_sel: ex_mem_q.wb_sel, wr_en: ex_mem_q.wr_en};

	pipe_reg #(.payload_t(mem_wb_t)) u_mem_wb (
		.CLK(CLK), .reset(reset), .en(1'b1), .bubble(1'b0), .d(mem_wb_d), .q(mem_wb_q)
	);

	// WB select
	always_comb begin
		case (mem_wb_q.wb_sel)
			wb_load: wb_data = mem_wb_q.ld_data;
			wb_imm:  wb_data = mem_wb_q.imm;
			default: wb_data = mem_wb_q.alu_res;
		endcase
	end

endmodule

//--- test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
	parameter int half_ns = 50	// 100 ns period
) (
	output logic CLK
);

	initial CLK = 1'b0;

	always #(half_ns) CLK = ~CLK;

endmodule

//--- test/core_assert.sv
`timescale 1ns/1ps

module core_assert (
	input logic                       CLK,
	input logic                       reset,
	input logic [3:0]                 con_write,
	input logic [core_pkg::dm_aw-1:0] con_addr,
	input logic [core_pkg::xlen-1:0]  con_in,
	input logic [core_pkg::xlen-1:0]  con_out,
	input logic                       stall,
	input logic [core_pkg::xlen-1:0]  id_inst,
	input logic                       id_ex_wr_en,
	input logic                       mem_wb_wr_en
);

	import core_pkg::*;

	int              fail_count = 0;	// Read back by core_tb
	logic [xlen-1:0] x_word;		// Word written to address 0 by the controller
	logic            done;		// Sentinel seen at word 9
	logic            reading;
	logic [xlen-1:0] sum_word;	// 2X+5
	logic [xlen-1:0] exp_word;

	//////////////////////////////////////////////////////////////////////
	// Reference state from the protocol port
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge CLK) begin
		if (con_write == 4'hf && con_addr == '0) x_word <= con_in;	// Also during reset
		if (reset) begin
			done <= 1'b0;
		end else if (con_addr == dm_aw'(9) && con_out == 32'h0000_600d) begin
			done <= 1'b1;
		end
	end

	assign reading  = done && (con_write == 4'b0);
	assign sum_word = (x_word + 32'd5) + x_word;	// add x3,x2,x1

	// Expected memory image after one pass of the program
	always_comb begin
		case (con_addr)
			10'd0:   exp_word = x_word;
			10'd1:   exp_word = x_word + 32'd5;
			10'd2:   exp_word = sum_word;
			10'd3:   exp_word = sum_word & x_word;
			10'd5:   exp_word = {16'b0, x_word[7:0], 8'b0};	// sb to byte 21
			10'd6:   exp_word = {24'b0, x_word[7:0]};
			default: exp_word = '0;			// Words 4 and 7
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Memory image through the protocol port
	//////////////////////////////////////////////////////////////////////
	word0_readback: assert property (@(posedge CLK) disable iff (reset)
		(reading && con_addr == 10'd0) |-> con_out == exp_word)
		else begin
			fail_count++;
			$error("error t=%0t con_out=%h expected %h", $time, con_out, exp_word);
		end

	load_use_fwd: assert property (@(posedge CLK) disable iff (reset)
		(reading && (con_addr == 10'd1 || con_addr == 10'd2)) |-> con_out == exp_word)
		else begin
			fail_count++;
			$error("error t=%0t con_out=%h expected %h", $time, con_out, exp_word);
		end

	logic_store_fwd: assert property (@(posedge CLK) disable iff (reset)
		(reading && con_addr == 10'd3) |-> con_out == exp_word)
		else begin
			fail_count++;
			$error("error t=%0t con_out=%h expected %h", $time, con_out, exp_word);
		end

	byte_lanes: assert property (@(posedge CLK) disable iff (reset)
		(reading && (con_addr == 10'd5 || con_addr == 10'd6)) |-> con_out == exp_word)
		else begin
			fail_count++;
			$error("error t=%0t con_out=%h expected %h", $time, con_out, exp_word);
		end

	zero_words: assert property (@(posedge CLK) disable iff (reset)
		(reading && (con_addr == 10'd4 || con_addr == 10'd7)) |-> con_out == exp_word)
		else begin
			fail_count++;
			$error("error t=%0t con_out=%h expected %h", $time, con_out, exp_word);
		end

	//////////////////////////////////////////////////////////////////////
	// Pipeline control
	//////////////////////////////////////////////////////////////////////
	// Dependent instruction stays in ID through the stall cycle
	fetch_hold: assert property (@(posedge CLK) disable iff (reset)
		stall |=> $stable(id_inst))
		else begin
			fail_count++;
			$error("IF/ID instruction moved on during a load-use stall");
		end

	stall_bubble: assert property (@(posedge CLK) disable iff (reset) stall |=> !id_ex_wr_en)
		else begin
			fail_count++;
			$error("ID/EXE register did not take a bubble after a load-use stall");
		end

	// Checked on the edge after each reset cycle
	reset_empty: assert property (@(posedge CLK) reset |=> (!id_ex_wr_en && !mem_wb_wr_en))
		else begin
			fail_count++;
			$error("pipeline register still holds a write after reset");
		end

endmodule

bind core core_assert u_check (
	.CLK(CLK), .reset(reset), .con_write(con_write), .con_addr(con_addr),
	.con_in(con_in), .con_out(con_out), .stall(stall), .id_inst(id_inst),
	.id_ex_wr_en(id_ex_q.wr_en), .mem_wb_wr_en(mem_wb_q.wr_en)
);

//--- test/core_tb.sv
`timescale 1ns/1ps

module core_tb;

	import core_pkg::*;

	localparam int poll_limit = 200;	// Cycles to wait for the sentinel

	logic             CLK;
	logic             reset;
	logic [3:0]       con_write;
	logic [dm_aw-1:0] con_addr;
	logic [xlen-1:0]  con_in;
	logic [xlen-1:0]  con_out;
	logic [xlen-1:0]  x_word;	// Random input word
	logic             found;
	int               timeouts;
	int               assert_fails;

	tb_clock u_clk (.CLK(CLK));

	core uut (
		.CLK(CLK), .reset(reset), .con_write(con_write), .con_addr(con_addr),
		.con_in(con_in), .con_out(con_out)
	);

	// Point the protocol port at a word and wait until it holds a value
	task automatic poll_word(input logic [dm_aw-1:0] addr, input logic [xlen-1:0] value,
		input int limit, output logic hit);
		int n;
		hit = 1'b0;
		n   = 0;
		@(negedge CLK);
		con_addr = addr;
		while (!hit && n < limit) begin
			@(negedge CLK);
			if (con_out == value) hit = 1'b1;	// Sampled mid-cycle, memory is stable
			n++;
		end
	endtask

	// Hold one address for a full cycle so the checks see it at the rising edge
	task automatic read_word(input logic [dm_aw-1:0] addr);
		@(negedge CLK);
		con_addr = addr;
	endtask

	initial begin
		void'($urandom(99011));
		x_word    = $urandom();
		reset     = 1'b1;
		con_write = 4'b0;
		con_addr  = '0;
		con_in    = '0;
		timeouts  = 0;

		// Word 0 gets X while the core sits in reset
		@(negedge CLK);
		con_write = 4'hf;
		con_in    = x_word;
		@(negedge CLK);
		con_write = 4'b0;
		reset     = 1'b0;	// Two rising edges under reset

		poll_word(dm_aw'(9), 32'h0000_600d, poll_limit, found);
		if (!found) begin
			timeouts++;
			$display("timeout: word 9 never held the sentinel within %0d cycles", poll_limit);
		end

		for (int i = 0; i < 8; i++) begin
			read_word(dm_aw'(i));
		end
		@(negedge CLK);
		@(negedge CLK);

		assert_fails = uut.u_check.fail_count;
		$display("timeouts=%0d assertion_failures=%0d", timeouts, assert_fails);
		if (timeouts == 0 && assert_fails == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

//--- test/program.hex
// One 32-bit instruction word per line, starting at address 0
// Word in hex, then the assembly it encodes
00002083 // lw   x1,0(x0)
00508113 // addi x2,x1,5
001101B3 // add  x3,x2,x1
0011F2B3 // and  x5,x3,x1
00202223 // sw   x2,4(x0)
00302423 // sw   x3,8(x0)
00502623 // sw   x5,12(x0)
00100AA3 // sb   x1,21(x0)
01504383 // lbu  x7,21(x0)
00702C23 // sw   x7,24(x0)
00700013 // addi x0,x0,7
00002E23 // sw   x0,28(x0)
00006437 // lui  x8,6
00D40413 // addi x8,x8,13
02802223 // sw   x8,36(x0)

//--- core.f
src/core_pkg.sv
src/pipe_reg.sv
src/fetch_unit.sv
src/decoder.sv
src/regfile.sv
src/alu.sv
src/datamem.sv
src/core.sv
test/tb_clock.sv
test/core_assert.sv
test/core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= core.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# The instruction ROM loads program.hex from the working directory
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	cd test && ../$(OBJ_DIR)/V$(TOP) > ../$(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG) || ! grep -q "=== PASS ===" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
